// File: source/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// datapath widths in bits
`define LSU_ADDR_W 64
`define LSU_DATA_W 64

// ram window, depth in doublewords
`define LSU_MEM_DEPTH 256
`define LSU_MEM_BASE 64'h0000_0000_8000_0000

// queue depth and starting credits of both loops
`define LSU_CREDITS 4

`endif

// File: source/lsu_pkg.sv
package lsu_pkg;

  // memory operations issued by the requester
  typedef enum logic [3:0] {
    OP_LB  = 4'd0,
    OP_LH  = 4'd1,
    OP_LW  = 4'd2,
    OP_LD  = 4'd3,
    OP_LBU = 4'd4,
    OP_LHU = 4'd5,
    OP_LWU = 4'd6,
    OP_SB  = 4'd7,
    OP_SH  = 4'd8,
    OP_SW  = 4'd9,
    OP_SD  = 4'd10
  } mem_op_e;

  // one-hot access size, same bit order as the access block mask
  typedef enum logic [3:0] {
    SIZE_D = 4'b0001,
    SIZE_W = 4'b0010,
    SIZE_H = 4'b0100,
    SIZE_B = 4'b1000
  } size_e;

endpackage

// File: source/req_fifo.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module req_fifo import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push,
  input  mem_op_e                push_op,
  input  logic [`LSU_ADDR_W-1:0] push_addr,
  input  logic [`LSU_DATA_W-1:0] push_wdata,
  input  logic                   pop,
  output logic                   empty,
  output mem_op_e                head_op,
  output logic [`LSU_ADDR_W-1:0] head_addr,
  output logic [`LSU_DATA_W-1:0] head_wdata
);

  localparam int DEPTH = `LSU_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  mem_op_e                op_q    [DEPTH];
  logic [`LSU_ADDR_W-1:0] addr_q  [DEPTH];
  logic [`LSU_DATA_W-1:0] wdata_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_pop;

  // wrap explicitly so a depth that is not a power of two still works
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty  = (count == '0);
  assign full   = (count == (PTR_W + 1)'(DEPTH));
  assign do_pop = pop && !empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      op_q[wr_ptr]    <= push_op;
      addr_q[wr_ptr]  <= push_addr;
      wdata_q[wr_ptr] <= push_wdata;
    end
  end

  assign head_op    = op_q[rd_ptr];
  assign head_addr  = addr_q[rd_ptr];
  assign head_wdata = wdata_q[rd_ptr];

  // requester may only push while it holds a credit, so the queue never overflows
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
    else $error("req_fifo: push while full");

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module data_ram (
  input  logic                   clk,
  input  logic [7:0]             index,
  input  logic [7:0]             byte_we,
  input  logic [`LSU_DATA_W-1:0] wdata,
  output logic [`LSU_DATA_W-1:0] rdata
);

  localparam int DEPTH = `LSU_MEM_DEPTH;
  localparam int LANES = `LSU_DATA_W / 8;

  logic [`LSU_DATA_W-1:0] mem [DEPTH];

  // one write port, each byte lane enabled on its own
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      if (byte_we[i]) begin
        mem[index][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  // asynchronous read of the addressed doubleword
  assign rdata = mem[index];

endmodule

// File: source/mem_access.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module mem_access import lsu_pkg::*; (
  input  logic                   ena,
  input  logic                   wen,
  input  size_e                  size,
  input  logic [`LSU_ADDR_W-1:0] addr,
  input  logic [`LSU_DATA_W-1:0] wdata,
  output logic [7:0]             index,
  output logic [7:0]             byte_we,
  output logic [`LSU_DATA_W-1:0] ram_wdata,
  input  logic [`LSU_DATA_W-1:0] ram_rdata,
  output logic [`LSU_DATA_W-1:0] rdata,
  output logic                   fault
);

  localparam int ADDR_W = `LSU_ADDR_W;
  localparam logic [ADDR_W-1:0] WIN_BASE  = `LSU_MEM_BASE;
  localparam logic [ADDR_W-1:0] WIN_BYTES = ADDR_W'(`LSU_MEM_DEPTH * 8);

  logic [2:0]             offset;
  logic [5:0]             shift;
  logic [7:0]             lane_mask;
  logic [`LSU_DATA_W-1:0] lane_bits;
  logic [ADDR_W-1:0]      rel_addr;
  logic                   in_window;

  assign offset = addr[2:0];
  assign shift  = {offset, 3'b000};

  // byte offset inside the window, doubleword index taken from it
  assign rel_addr  = addr - WIN_BASE;
  assign in_window = (addr >= WIN_BASE) && (rel_addr < WIN_BYTES);
  assign index     = rel_addr[3 +: 8];

  // lane mask, empty for any misaligned access
  always_comb begin
    lane_mask = 8'h00;
    case (size)
      SIZE_D: begin
        if (offset == 3'd0) begin
          lane_mask = 8'hff;
        end
      end
      SIZE_W: begin
        if (offset == 3'd0) begin
          lane_mask = 8'h0f;
        end else if (offset == 3'd4) begin
          lane_mask = 8'hf0;
        end
      end
      SIZE_H: begin
        if (!offset[0]) begin
          lane_mask = 8'h03 << offset;
        end
      end
      SIZE_B:  lane_mask = 8'h01 << offset;
      default: lane_mask = 8'h00;
    endcase
  end

  // widen the lane mask to bit granularity
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      lane_bits[i*8 +: 8] = {8{lane_mask[i]}};
    end
  end

  assign fault = ena && ((lane_mask == 8'h00) || !in_window);

  // a faulting access touches no lane
  assign byte_we   = (ena && wen && !fault) ? lane_mask : 8'h00;
  assign ram_wdata = wdata << shift;

  // selected lanes moved down to bit 0
  assign rdata = fault ? '0 : ((ram_rdata & lane_bits) >> shift);

  // decode in the unit must always hand over a legal size
  always_comb begin
    if (ena) begin
      a_size_onehot: assert ($onehot(size))
        else $error("mem_access: size %b not one-hot", size);
    end
  end

endmodule

// File: source/load_store_unit.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module load_store_unit import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fifo_empty,
  input  mem_op_e                head_op,
  input  logic [`LSU_ADDR_W-1:0] head_addr,
  input  logic [`LSU_DATA_W-1:0] head_wdata,
  output logic                   pop,
  output logic                   req_credit,
  input  logic                   rsp_credit,
  output logic                   acc_ena,
  output logic                   acc_wen,
  output size_e                  acc_size,
  output logic [`LSU_ADDR_W-1:0] acc_addr,
  output logic [`LSU_DATA_W-1:0] acc_wdata,
  input  logic [`LSU_DATA_W-1:0] acc_rdata,
  input  logic                   acc_fault,
  output logic                   rsp_valid,
  output logic [`LSU_DATA_W-1:0] rsp_data,
  output logic                   rsp_err
);

  localparam int CNT_W = $clog2(`LSU_CREDITS) + 1;
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`LSU_CREDITS);

  logic [CNT_W-1:0]       rsp_cnt;
  logic                   exec_valid;
  mem_op_e                exec_op;
  logic [`LSU_ADDR_W-1:0] exec_addr;
  logic [`LSU_DATA_W-1:0] exec_wdata;
  logic                   exec_wen;
  logic                   exec_signed;
  size_e                  exec_size;
  logic                   sign_bit;
  logic [`LSU_DATA_W-1:0] ext_data;

  // take a request only if a response slot is guaranteed downstream
  assign pop        = !fifo_empty && (rsp_cnt != '0);
  assign req_credit = pop;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_cnt <= CNT_FULL;
    end else begin
      rsp_cnt <= rsp_cnt - CNT_W'(pop) + CNT_W'(rsp_credit);
    end
  end

  // execute stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exec_valid <= 1'b0;
    end else begin
      exec_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      exec_op    <= head_op;
      exec_addr  <= head_addr;
      exec_wdata <= head_wdata;
    end
  end

  // operation decode
  always_comb begin
    exec_wen    = exec_op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    exec_signed = exec_op inside {OP_LB, OP_LH, OP_LW, OP_LD};
    case (exec_op)
      OP_LB, OP_LBU, OP_SB: exec_size = SIZE_B;
      OP_LH, OP_LHU, OP_SH: exec_size = SIZE_H;
      OP_LW, OP_LWU, OP_SW: exec_size = SIZE_W;
      OP_LD, OP_SD:         exec_size = SIZE_D;
      // unknown opcode, caught by the size check in the access block
      default:              exec_size = size_e'(4'b0000);
    endcase
  end

  assign acc_ena   = exec_valid;
  assign acc_wen   = exec_wen;
  assign acc_size  = exec_size;
  assign acc_addr  = exec_addr;
  assign acc_wdata = exec_wdata;

  // sign or zero extension of the aligned load data
  always_comb begin
    sign_bit = 1'b0;
    ext_data = acc_rdata;
    case (exec_size)
      SIZE_B: begin
        sign_bit = exec_signed && acc_rdata[7];
        ext_data = {{56{sign_bit}}, acc_rdata[7:0]};
      end
      SIZE_H: begin
        sign_bit = exec_signed && acc_rdata[15];
        ext_data = {{48{sign_bit}}, acc_rdata[15:0]};
      end
      SIZE_W: begin
        sign_bit = exec_signed && acc_rdata[31];
        ext_data = {{32{sign_bit}}, acc_rdata[31:0]};
      end
      default: ext_data = acc_rdata;
    endcase
  end

  // response stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= exec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exec_valid) begin
      rsp_data <= exec_wen ? '0 : ext_data;
      rsp_err  <= acc_fault;
    end
  end

  // consumer returns at most what was handed out
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_credit |-> (rsp_cnt != CNT_FULL))
    else $error("load_store_unit: rsp_credit with counter full");

endmodule

// File: source/lsu_top.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  mem_op_e                req_op,
  input  logic [`LSU_ADDR_W-1:0] req_addr,
  input  logic [`LSU_DATA_W-1:0] req_wdata,
  output logic                   req_credit,
  output logic                   rsp_valid,
  output logic [`LSU_DATA_W-1:0] rsp_data,
  output logic                   rsp_err,
  input  logic                   rsp_credit
);

  // queue head
  logic                   fifo_empty;
  logic                   fifo_pop;
  mem_op_e                head_op;
  logic [`LSU_ADDR_W-1:0] head_addr;
  logic [`LSU_DATA_W-1:0] head_wdata;

  // access block side
  logic                   acc_ena;
  logic                   acc_wen;
  size_e                  acc_size;
  logic [`LSU_ADDR_W-1:0] acc_addr;
  logic [`LSU_DATA_W-1:0] acc_wdata;
  logic [`LSU_DATA_W-1:0] acc_rdata;
  logic                   acc_fault;

  // ram port
  logic [7:0]             ram_index;
  logic [7:0]             ram_byte_we;
  logic [`LSU_DATA_W-1:0] ram_wdata;
  logic [`LSU_DATA_W-1:0] ram_rdata;

  req_fifo u_req_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (req_valid),
    .push_op    (req_op),
    .push_addr  (req_addr),
    .push_wdata (req_wdata),
    .pop        (fifo_pop),
    .empty      (fifo_empty),
    .head_op    (head_op),
    .head_addr  (head_addr),
    .head_wdata (head_wdata)
  );

  load_store_unit u_lsu (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_empty (fifo_empty),
    .head_op    (head_op),
    .head_addr  (head_addr),
    .head_wdata (head_wdata),
    .pop        (fifo_pop),
    .req_credit (req_credit),
    .rsp_credit (rsp_credit),
    .acc_ena    (acc_ena),
    .acc_wen    (acc_wen),
    .acc_size   (acc_size),
    .acc_addr   (acc_addr),
    .acc_wdata  (acc_wdata),
    .acc_rdata  (acc_rdata),
    .acc_fault  (acc_fault),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_err    (rsp_err)
  );

  mem_access u_mem_access (
    .ena       (acc_ena),
    .wen       (acc_wen),
    .size      (acc_size),
    .addr      (acc_addr),
    .wdata     (acc_wdata),
    .index     (ram_index),
    .byte_we   (ram_byte_we),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .rdata     (acc_rdata),
    .fault     (acc_fault)
  );

  data_ram u_data_ram (
    .clk     (clk),
    .index   (ram_index),
    .byte_we (ram_byte_we),
    .wdata   (ram_wdata),
    .rdata   (ram_rdata)
  );

endmodule

// File: testbench/tb_lsu.sv
`timescale 1ns/1ns
`include "lsu_defs.svh"

module tb_lsu import lsu_pkg::*; ();

  localparam logic [63:0] BASE = `LSU_MEM_BASE;
  localparam int WIN_BYTES = `LSU_MEM_DEPTH * 8;
  // fill and readback, sub-word, faults, back-pressure, random mix
  localparam int TOTAL_REQ = 2 * `LSU_MEM_DEPTH + 112 + 14 + 2 * `LSU_CREDITS + 200;
  localparam int WATCHDOG_CYCLES = TOTAL_REQ * 20 + 500;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  mem_op_e     req_op;
  logic [63:0] req_addr;
  logic [63:0] req_wdata;
  logic        req_credit;
  logic        rsp_valid;
  logic [63:0] rsp_data;
  logic        rsp_err;
  logic        rsp_credit = 1'b0;

  // byte model of the ram window and the in-order expected responses
  logic [7:0]  ref_mem [WIN_BYTES];
  logic [63:0] exp_data [$];
  logic        exp_err [$];
  logic [63:0] exp_addr [$];

  logic [15:0] lfsr = 16'd24751;
  logic        hold_credit = 1'b0;
  int          errors = 0;
  int          rsp_errors = 0;
  int          sent = 0;
  int          credits_back = 0;
  int          rsp_count = 0;
  int          credits_given = 0;

  lsu_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_err    (rsp_err),
    .rsp_credit (rsp_credit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
        lfsr = lfsr ^ 16'hb400;
      end
      r = {r[62:0], b};
    end
    return r;
  endfunction

  // expected response of one access, stores update the byte model
  function automatic void model_access(input mem_op_e op, input logic [63:0] addr,
                                       input logic [63:0] wdata);
    int          nbytes;
    logic        is_store;
    logic        bad;
    logic [63:0] rel;
    logic [63:0] val;
    case (op)
      OP_LB, OP_LBU, OP_SB: nbytes = 1;
      OP_LH, OP_LHU, OP_SH: nbytes = 2;
      OP_LW, OP_LWU, OP_SW: nbytes = 4;
      default:              nbytes = 8;
    endcase
    is_store = op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    rel = addr - BASE;
    // natural alignment and the window bounds
    bad = (addr < BASE) || (rel >= 64'(WIN_BYTES)) || ((addr % nbytes) != 0);
    val = '0;
    if (!bad) begin
      for (int i = 0; i < nbytes; i++) begin
        if (is_store) begin
          ref_mem[rel + 64'(i)] = wdata[i*8 +: 8];
        end else begin
          val[i*8 +: 8] = ref_mem[rel + 64'(i)];
        end
      end
      if ((op inside {OP_LB, OP_LH, OP_LW}) && val[nbytes*8-1]) begin
        val = val | ~((64'd1 << (nbytes * 8)) - 64'd1);
      end
    end
    exp_data.push_back(val);
    exp_err.push_back(bad);
    exp_addr.push_back(addr);
  endfunction

  task automatic send(input mem_op_e op, input logic [63:0] addr, input logic [63:0] wdata);
    while (`LSU_CREDITS + credits_back - sent == 0) begin
      @(negedge clk);
    end
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = wdata;
    sent++;
    model_access(op, addr, wdata);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_data.size() != 0 || credits_given != rsp_count) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  // responses and credit pulses sampled on the rising edge
  always @(posedge clk) begin
    if (rst_n && rsp_valid) begin
      if (exp_data.size() == 0) begin
        $display("response arrived with no request outstanding");
        rsp_errors++;
      end else begin
        if (rsp_err !== exp_err[0]) begin
          $display("error: rsp_err at addr %h expected %h got %h", exp_addr[0], exp_err[0],
                   rsp_err);
          rsp_errors++;
        end else if (!exp_err[0] && rsp_data !== exp_data[0]) begin
          $display("error: rsp_data at addr %h expected %h got %h", exp_addr[0],
                   exp_data[0], rsp_data);
          rsp_errors++;
        end
        void'(exp_data.pop_front());
        void'(exp_err.pop_front());
        void'(exp_addr.pop_front());
      end
      rsp_count++;
    end
    if (rst_n && req_credit) begin
      credits_back++;
    end
  end

  // consumer hands back one response credit per drained response
  always @(negedge clk) begin
    if (!hold_credit && rsp_count > credits_given) begin
      rsp_credit = 1'b1;
      credits_given++;
    end else begin
      rsp_credit = 1'b0;
    end
  end

  task automatic test_fill_readback();
    logic [63:0] a;
    for (int i = 0; i < `LSU_MEM_DEPTH; i++) begin
      a = BASE + 64'(i * 8);
      send(OP_SD, a, rand_bits(64));
      send(OP_LD, a, '0);
    end
    drain();
  endtask

  task automatic test_sub_word();
    logic [63:0] a;
    for (int w = 0; w < 2; w++) begin
      // one word inside, then the last word of the window
      a = (w == 0) ? BASE + 64'h100 : BASE + 64'(WIN_BYTES - 8);
      // readback after each store shows the other lanes kept
      for (int o = 0; o < 8; o++) begin
        send(OP_SB, a + 64'(o), rand_bits(64));
        send(OP_LD, a, '0);
      end
      for (int o = 0; o < 8; o += 2) begin
        send(OP_SH, a + 64'(o), rand_bits(64));
        send(OP_LD, a, '0);
      end
      for (int o = 0; o < 8; o += 4) begin
        send(OP_SW, a + 64'(o), rand_bits(64));
        send(OP_LD, a, '0);
      end
      for (int o = 0; o < 8; o++) begin
        send(OP_LB, a + 64'(o), '0);
        send(OP_LBU, a + 64'(o), '0);
      end
      for (int o = 0; o < 8; o += 2) begin
        send(OP_LH, a + 64'(o), '0);
        send(OP_LHU, a + 64'(o), '0);
      end
      for (int o = 0; o < 8; o += 4) begin
        send(OP_LW, a + 64'(o), '0);
        send(OP_LWU, a + 64'(o), '0);
      end
    end
    drain();
  endtask

  task automatic test_faults();
    logic [63:0] a;
    a = BASE + 64'h200;
    send(OP_SH, a + 64'd1, rand_bits(64));
    send(OP_SW, a + 64'd2, rand_bits(64));
    send(OP_SD, a + 64'd4, rand_bits(64));
    send(OP_LH, a + 64'd3, '0);
    send(OP_LWU, a + 64'd6, '0);
    send(OP_LD, a + 64'd1, '0);
    send(OP_SD, BASE - 64'd8, rand_bits(64));
    send(OP_LB, BASE - 64'd1, '0);
    send(OP_SB, BASE + 64'(WIN_BYTES), rand_bits(64));
    send(OP_LD, BASE + 64'(WIN_BYTES) + 64'd8, '0);
    send(OP_SW, 64'd0, rand_bits(64));
    // untouched words read back unchanged
    send(OP_LD, a, '0);
    send(OP_LD, BASE, '0);
    // a store just below the base would wrap onto the last word
    send(OP_LD, BASE + 64'(WIN_BYTES - 8), '0);
    drain();
  endtask

  task automatic test_backpressure();
    int rsp_start;
    int cr_start;
    int waited;
    rsp_start = rsp_count;
    cr_start = credits_back;
    hold_credit = 1'b1;
    for (int i = 0; i < `LSU_CREDITS; i++) begin
      send(OP_SD, BASE + 64'h300 + 64'(i * 8), rand_bits(64));
    end
    for (int i = 0; i < `LSU_CREDITS; i++) begin
      send(OP_LD, BASE + 64'h300 + 64'(i * 8), '0);
    end
    waited = 0;
    while (rsp_count - rsp_start < `LSU_CREDITS && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (rsp_valid) begin
        $display("response delivered while all response credits were held");
        errors++;
      end
    end
    if (rsp_count - rsp_start != `LSU_CREDITS) begin
      $display("error: held responses expected %h got %h", `LSU_CREDITS, rsp_count - rsp_start);
      errors++;
    end
    hold_credit = 1'b0;
    drain();
    if (credits_back - cr_start != 2 * `LSU_CREDITS) begin
      $display("error: req_credit pulses expected %h got %h", 2 * `LSU_CREDITS,
               credits_back - cr_start);
      errors++;
    end
  endtask

  task automatic test_random();
    mem_op_e     op;
    logic [63:0] a;
    for (int i = 0; i < 200; i++) begin
      op = mem_op_e'(4'(rand_bits(4) % 11));
      a = BASE + rand_bits(11);
      // mostly aligned so that most accesses hit the ram
      if (rand_bits(2) != 0) begin
        a[2:0] = 3'b000;
      end
      if (rand_bits(4) == 0) begin
        if (rand_bits(1) == 1'b1) begin
          a = BASE - 64'd16 + rand_bits(3);
        end else begin
          a = a + 64'(WIN_BYTES);
        end
      end
      send(op, a, rand_bits(64));
    end
    drain();
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, responses still missing", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_op    = OP_LB;
    req_addr  = '0;
    req_wdata = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    test_fill_readback();
    test_sub_word();
    test_faults();
    test_backpressure();
    test_random();
    if (exp_data.size() != 0) begin
      $display("%0d responses never arrived", exp_data.size());
      errors++;
    end
    $display("summary: %0d requests, %0d responses, %0d test errors, %0d response errors",
             sent, rsp_count, errors, rsp_errors);
    if (errors + rsp_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+source
source/lsu_pkg.sv
source/req_fifo.sv
source/data_ram.sv
source/mem_access.sv
source/load_store_unit.sv
source/lsu_top.sv
testbench/tb_lsu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_lsu -o tb_lsu

./obj_dir/tb_lsu 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
